// ==== compile.f ====
+incdir+logic
logic/eth_lat_pkg.sv
logic/checksum_calculator.sv
logic/eth_latency_measurer_tx.sv
logic/eth_latency_measurer_rx.sv
logic/latency_timer.sv
logic/eth_latency_measurer.sv
testbench/eth_latency_measurer_tb.sv

// ==== logic/checksum_calculator.sv ====
// Serial ones-complement checksum
`timescale 1ns/1ps

module checksum_calculator #(
	parameter int N_WORDS = 6
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     trigger,
	input  logic [N_WORDS*16-1:0]    values,
	output eth_lat_pkg::id16_t       checksum
);
	localparam int CNT_W = $clog2(N_WORDS + 1);

	logic [N_WORDS*16-1:0] words; // Word 0 sits in the low bits
	logic [CNT_W-1:0] cnt;
	logic active;
	logic done;
	logic [15:0] sum;
	logic [16:0] sum_wide;

	assign sum_wide = {1'b0, sum} + {1'b0, words[15:0]};

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
			active <= 1'b0;
			done <= 1'b0;
			sum <= 16'h0000;
			checksum <= 16'h0000;
		end else if (trigger) begin
			cnt <= '0;
			active <= 1'b1;
			done <= 1'b0;
			sum <= 16'h0000;
		end else begin
			done <= 1'b0;
			if (active) begin
				sum <= sum_wide[15:0] + {15'd0, sum_wide[16]}; // End-around carry
				cnt <= cnt + 1'b1;
				if (cnt == CNT_W'(N_WORDS - 1)) begin
					active <= 1'b0;
					done <= 1'b1;
				end
			end
			if (done)
				checksum <= ~sum;
		end
	end

	always_ff @(posedge clk) begin
		if (trigger)
			words <= values;
		else if (active)
			words <= words >> 16;
	end

endmodule

// ==== logic/eth_lat_cfg.svh ====
// Latency measurer configuration
`ifndef ETH_LAT_CFG_SVH
`define ETH_LAT_CFG_SVH

// ********************
// Frame layout
// ********************

`define ETH_LAT_HDR_BYTES 42 // Ethernet, IPv4 and ICMP echo headers
`define ETH_LAT_PAD_EXTRA 18 // Added to padding_size for the padding length
`define ETH_LAT_PAD_BYTE 8'h55

// Checksum fields are swapped into the shift buffer after these byte indices
`define ETH_LAT_IP_CSUM_AT 23
`define ETH_LAT_ICMP_CSUM_AT 35
`define ETH_LAT_IP_CONST 16'hC51D // Folded sum of the fixed IP header words

`define ETH_LAT_TIMEOUT 4096 // Cycles before a ping is declared lost
`define ETH_LAT_CNT_W 32

`endif

// ==== logic/eth_lat_pkg.sv ====
// Latency measurer types
`include "eth_lat_cfg.svh"

package eth_lat_pkg;

	// ********************
	// Addresses
	// ********************

	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ip_addr_t;

	// ********************
	// Identifiers and counts
	// ********************

	typedef logic [15:0] id16_t; // Frame, log and ping ids, also the padding size

	typedef logic [`ETH_LAT_CNT_W-1:0] latency_t;

endpackage

// ==== logic/eth_latency_measurer.sv ====
// Ping latency measurer top level
`timescale 1ns/1ps

module eth_latency_measurer #(
	parameter int C_MODE = 0
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   trigger,

	input  eth_lat_pkg::mac_addr_t mac_addr_src,
	input  eth_lat_pkg::ip_addr_t  ip_addr_src,
	input  eth_lat_pkg::mac_addr_t mac_addr_dst,
	input  eth_lat_pkg::ip_addr_t  ip_addr_dst,
	input  eth_lat_pkg::id16_t     padding_size,
	input  eth_lat_pkg::id16_t     frame_id,
	input  eth_lat_pkg::id16_t     log_id,
	input  eth_lat_pkg::id16_t     ping_id,

	output logic [7:0]             m_axis_tdata,
	output logic                   m_axis_tkeep,
	output logic                   m_axis_tlast,
	output logic                   m_axis_tvalid,
	input  logic                   m_axis_tready,

	input  logic [7:0]             s_axis_tdata,
	input  logic                   s_axis_tvalid,
	input  logic                   s_axis_tlast,

	output eth_lat_pkg::latency_t  latency,
	output logic                   latency_valid,
	output logic                   timeout,
	output logic                   busy
);
	logic tx_begin;
	logic rx_match;

	// No new ping while one is outstanding
	eth_latency_measurer_tx #(.C_MODE(C_MODE)) tx0 (
		.clk           (clk),
		.rst           (rst),
		.trigger       (trigger & ~busy),
		.tx_begin      (tx_begin),
		.mac_addr_src  (mac_addr_src),
		.ip_addr_src   (ip_addr_src),
		.mac_addr_dst  (mac_addr_dst),
		.ip_addr_dst   (ip_addr_dst),
		.padding_size  (padding_size),
		.frame_id      (frame_id),
		.log_id        (log_id),
		.ping_id       (ping_id),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tkeep  (m_axis_tkeep),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready)
	);

	eth_latency_measurer_rx rx0 (
		.clk           (clk),
		.rst           (rst),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tlast  (s_axis_tlast),
		.mac_addr_src  (mac_addr_src),
		.ip_addr_src   (ip_addr_src),
		.log_id        (log_id),
		.ping_id       (ping_id),
		.rx_match      (rx_match)
	);

	latency_timer timer0 (
		.clk           (clk),
		.rst           (rst),
		.tx_begin      (tx_begin),
		.rx_match      (rx_match),
		.latency       (latency),
		.latency_valid (latency_valid),
		.timeout       (timeout),
		.busy          (busy)
	);

endmodule

// ==== logic/eth_latency_measurer_rx.sv ====
// Echo reply parser
`timescale 1ns/1ps
`include "eth_lat_cfg.svh"

module eth_latency_measurer_rx (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [7:0]             s_axis_tdata,
	input  logic                   s_axis_tvalid,
	input  logic                   s_axis_tlast,
	input  eth_lat_pkg::mac_addr_t mac_addr_src,
	input  eth_lat_pkg::ip_addr_t  ip_addr_src,
	input  eth_lat_pkg::id16_t     log_id,
	input  eth_lat_pkg::id16_t     ping_id,
	output logic                   rx_match
);
	logic [5:0] cnt; // Saturates past the header
	logic match;
	logic match_now;
	logic chk;
	logic [7:0] exp_byte;

	// ********************
	// Expected header bytes
	// ********************

	always_comb begin
		chk = 1'b1;
		exp_byte = 8'h00;
		if (cnt <= 6'd5)
			exp_byte = mac_addr_src[8*(5 - cnt) +: 8]; // Reply goes to our MAC
		else if (cnt == 6'd12)
			exp_byte = 8'h08;
		else if (cnt == 6'd13)
			exp_byte = 8'h00;
		else if (cnt == 6'd23)
			exp_byte = 8'h01; // ICMP protocol
		else if (cnt >= 6'd30 && cnt <= 6'd33)
			exp_byte = ip_addr_src[8*(33 - cnt) +: 8];
		else if (cnt == 6'd34)
			exp_byte = 8'h00; // Echo reply type
		else if (cnt == 6'd38)
			exp_byte = log_id[15:8];
		else if (cnt == 6'd39)
			exp_byte = log_id[7:0];
		else if (cnt == 6'd40)
			exp_byte = ping_id[15:8];
		else if (cnt == 6'd41)
			exp_byte = ping_id[7:0];
		else
			chk = 1'b0;
	end

	assign match_now = match && !(chk && s_axis_tdata != exp_byte);

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= 6'd0;
			match <= 1'b1;
		end else if (s_axis_tvalid) begin
			if (s_axis_tlast) begin
				cnt <= 6'd0;
				match <= 1'b1;
			end else begin
				match <= match_now;
				if (cnt != 6'h3F)
					cnt <= cnt + 6'd1;
			end
		end
	end

	// A frame shorter than the header never matches
	assign rx_match = s_axis_tvalid && s_axis_tlast && match_now &&
		(cnt >= 6'(`ETH_LAT_HDR_BYTES - 1));

endmodule

// ==== logic/eth_latency_measurer_tx.sv ====
// Echo frame transmitter
`timescale 1ns/1ps
`include "eth_lat_cfg.svh"

module eth_latency_measurer_tx #(
	parameter int C_MODE = 0
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   trigger,
	output logic                   tx_begin,

	input  eth_lat_pkg::mac_addr_t mac_addr_src,
	input  eth_lat_pkg::ip_addr_t  ip_addr_src,
	input  eth_lat_pkg::mac_addr_t mac_addr_dst,
	input  eth_lat_pkg::ip_addr_t  ip_addr_dst,
	input  eth_lat_pkg::id16_t     padding_size,
	input  eth_lat_pkg::id16_t     frame_id,
	input  eth_lat_pkg::id16_t     log_id,
	input  eth_lat_pkg::id16_t     ping_id,

	output logic [7:0]             m_axis_tdata,
	output logic                   m_axis_tkeep,
	output logic                   m_axis_tlast,
	output logic                   m_axis_tvalid,
	input  logic                   m_axis_tready
);
	localparam int HDR_W = `ETH_LAT_HDR_BYTES * 8;
	localparam int ICMP_WORDS = (C_MODE != 0) ? 2 : 3;
	localparam logic [7:0] ICMP_TYPE = (C_MODE != 0) ? 8'h00 : 8'h08;

	typedef enum logic [1:0] {ST_WAIT_TRIGGER, ST_SEND_HEADERS, ST_SEND_PADDING} state_t;

	state_t state;
	logic [15:0] count;
	logic [HDR_W-1:0] tx_buffer; // Next byte to send is in the top bits
	eth_lat_pkg::id16_t ip_checksum;
	eth_lat_pkg::id16_t icmp_checksum;
	eth_lat_pkg::id16_t pad_last;
	logic [ICMP_WORDS*16-1:0] icmp_words;
	logic start;
	logic accept;
	logic csum_clear;
	logic last_hdr;
	logic last_pad;

	assign start = trigger && (state == ST_WAIT_TRIGGER);
	assign accept = m_axis_tvalid && m_axis_tready;
	assign csum_clear = rst || (state == ST_SEND_PADDING);
	assign pad_last = padding_size + 16'(`ETH_LAT_PAD_EXTRA - 1);
	assign last_hdr = (count == 16'(`ETH_LAT_HDR_BYTES - 1));
	assign last_pad = (count == pad_last);

	// ********************
	// Frame sequencing
	// ********************

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_WAIT_TRIGGER;
			count <= 16'd0;
		end else begin
			case (state)
				ST_WAIT_TRIGGER: if (trigger) begin
					state <= ST_SEND_HEADERS;
					count <= 16'd0;
				end
				ST_SEND_HEADERS: if (accept) begin
					count <= last_hdr ? 16'd0 : count + 16'd1;
					if (last_hdr)
						state <= ST_SEND_PADDING;
				end
				ST_SEND_PADDING: if (accept) begin
					count <= last_pad ? 16'd0 : count + 16'd1;
					if (last_pad)
						state <= ST_WAIT_TRIGGER;
				end
				default: state <= ST_WAIT_TRIGGER;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			tx_buffer <= {mac_addr_dst, mac_addr_src, 48'h0800_4500_001C, frame_id,
				48'h4000_4001_0000, ip_addr_src, ip_addr_dst, ICMP_TYPE, 24'd0,
				log_id, ping_id};
		end else if (accept && state == ST_SEND_HEADERS) begin
			if (count == `ETH_LAT_IP_CSUM_AT)
				tx_buffer <= {ip_checksum, tx_buffer[HDR_W-25:0], 8'd0};
			else if (count == `ETH_LAT_ICMP_CSUM_AT)
				tx_buffer <= {icmp_checksum, tx_buffer[HDR_W-25:0], 8'd0};
			else
				tx_buffer <= {tx_buffer[HDR_W-9:0], 8'd0};
		end
	end

	assign m_axis_tvalid = (state != ST_WAIT_TRIGGER);
	assign m_axis_tdata = (state == ST_SEND_HEADERS) ? tx_buffer[HDR_W-1 -: 8] : `ETH_LAT_PAD_BYTE;
	assign m_axis_tlast = (state == ST_SEND_PADDING) && last_pad;
	assign m_axis_tkeep = 1'b1;
	assign tx_begin = (state == ST_SEND_HEADERS) && (count == 16'd0) && m_axis_tready;

	// ********************
	// Checksums
	// ********************

	if (C_MODE != 0) begin : g_reply
		assign icmp_words = {ping_id, log_id}; // Type and code word is zero
	end else begin : g_request
		assign icmp_words = {ping_id, log_id, ICMP_TYPE, 8'h00};
	end

	checksum_calculator #(.N_WORDS(6)) ip_csum0 (
		.clk      (clk),
		.rst      (csum_clear),
		.trigger  (start),
		.values   ({frame_id, ip_addr_dst, ip_addr_src, `ETH_LAT_IP_CONST}),
		.checksum (ip_checksum)
	);

	checksum_calculator #(.N_WORDS(ICMP_WORDS)) icmp_csum0 (
		.clk      (clk),
		.rst      (csum_clear),
		.trigger  (start),
		.values   (icmp_words),
		.checksum (icmp_checksum)
	);

endmodule

// ==== logic/latency_timer.sv ====
// Round-trip latency timer
`timescale 1ns/1ps
`include "eth_lat_cfg.svh"

module latency_timer (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  tx_begin,
	input  logic                  rx_match,
	output eth_lat_pkg::latency_t latency,
	output logic                  latency_valid,
	output logic                  timeout,
	output logic                  busy
);
	eth_lat_pkg::latency_t count;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
			latency <= '0;
			latency_valid <= 1'b0;
			timeout <= 1'b0;
			busy <= 1'b0;
		end else begin
			latency_valid <= 1'b0;
			timeout <= 1'b0;
			if (!busy) begin
				if (tx_begin) begin
					busy <= 1'b1;
					count <= eth_lat_pkg::latency_t'(1); // Edge at the end of the tx_begin cycle
				end
			end else if (rx_match) begin
				busy <= 1'b0;
				latency <= count;
				latency_valid <= 1'b1;
			end else if (count == eth_lat_pkg::latency_t'(`ETH_LAT_TIMEOUT)) begin
				busy <= 1'b0;
				timeout <= 1'b1;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

// ==== testbench/eth_latency_measurer_tb.sv ====
// Latency measurer testbench
`timescale 1ns/1ps
`include "eth_lat_cfg.svh"

module eth_latency_measurer_tb;
	localparam int MAX_BYTES = 128;

	logic clk;
	logic rst;
	logic trigger;
	eth_lat_pkg::mac_addr_t mac_addr_src;
	eth_lat_pkg::ip_addr_t ip_addr_src;
	eth_lat_pkg::mac_addr_t mac_addr_dst;
	eth_lat_pkg::ip_addr_t ip_addr_dst;
	eth_lat_pkg::id16_t padding_size;
	eth_lat_pkg::id16_t frame_id;
	eth_lat_pkg::id16_t log_id;
	eth_lat_pkg::id16_t ping_id;
	logic [7:0] m_axis_tdata;
	logic m_axis_tkeep;
	logic m_axis_tlast;
	logic m_axis_tvalid;
	logic m_axis_tready;
	logic [7:0] s_axis_tdata;
	logic s_axis_tvalid;
	logic s_axis_tlast;
	eth_lat_pkg::latency_t latency;
	logic latency_valid;
	logic timeout;
	logic busy;

	logic [7:0] exp_frame [0:MAX_BYTES-1];
	logic [7:0] got_frame [0:MAX_BYTES-1];
	logic got_last [0:MAX_BYTES-1];
	int exp_len;
	int got_len;
	int frame_len; // Length of the last captured frame
	int frames_seen;
	int valid_seen;
	int timeouts_seen;
	int cyc;
	int begin_cyc;
	int timeout_cyc;
	eth_lat_pkg::latency_t exp_latency;
	int byte_errors;
	int word_errors;
	int latency_errors;
	int flag_errors;
	int other_errors;
	integer seed;
	logic stall_mode;
	logic prev_stall;
	logic [7:0] prev_data;
	logic prev_last;
	event frame_captured;

	eth_latency_measurer #(.C_MODE(0)) dut0 (
		.clk           (clk),
		.rst           (rst),
		.trigger       (trigger),
		.mac_addr_src  (mac_addr_src),
		.ip_addr_src   (ip_addr_src),
		.mac_addr_dst  (mac_addr_dst),
		.ip_addr_dst   (ip_addr_dst),
		.padding_size  (padding_size),
		.frame_id      (frame_id),
		.log_id        (log_id),
		.ping_id       (ping_id),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tkeep  (m_axis_tkeep),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tlast  (s_axis_tlast),
		.latency       (latency),
		.latency_valid (latency_valid),
		.timeout       (timeout),
		.busy          (busy)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	always @(posedge clk) begin
		#1;
		if (stall_mode)
			m_axis_tready = (($random(seed) & 3) != 0); // Stalls about one cycle in four
		else
			m_axis_tready = 1'b1;
	end

	// ********************
	// Reference model
	// ********************

	function automatic eth_lat_pkg::id16_t add_ones(input eth_lat_pkg::id16_t acc,
			input eth_lat_pkg::id16_t word);
		logic [16:0] s;
		s = {1'b0, acc} + {1'b0, word};
		return s[15:0] + {15'd0, s[16]};
	endfunction

	function automatic eth_lat_pkg::id16_t region_sum(input int first, input int nwords);
		eth_lat_pkg::id16_t acc;
		acc = 16'h0000;
		for (int i = 0; i < nwords; i++)
			acc = add_ones(acc, {got_frame[first + 2*i], got_frame[first + 2*i + 1]});
		return acc;
	endfunction

	// Ethernet II, IPv4 without options, ICMP echo request, then padding
	function automatic int build_frame(input eth_lat_pkg::id16_t pad);
		logic [8*`ETH_LAT_HDR_BYTES-1:0] hdr;
		eth_lat_pkg::id16_t acc;
		int len;
		len = `ETH_LAT_HDR_BYTES + int'(pad) + `ETH_LAT_PAD_EXTRA;
		hdr = {mac_addr_dst, mac_addr_src, 16'h0800, 16'h4500, 16'd28, frame_id,
			16'h4000, 8'd64, 8'd1, 16'h0000, ip_addr_src, ip_addr_dst,
			8'd8, 8'd0, 16'h0000, log_id, ping_id};
		for (int i = 0; i < `ETH_LAT_HDR_BYTES; i++)
			exp_frame[i] = hdr[8*(`ETH_LAT_HDR_BYTES - 1 - i) +: 8];
		for (int i = `ETH_LAT_HDR_BYTES; i < len && i < MAX_BYTES; i++)
			exp_frame[i] = `ETH_LAT_PAD_BYTE;
		acc = 16'h0000;
		for (int i = 0; i < 10; i++)
			acc = add_ones(acc, {exp_frame[14 + 2*i], exp_frame[15 + 2*i]});
		exp_frame[24] = ~acc[15:8];
		exp_frame[25] = ~acc[7:0];
		acc = 16'h0000;
		for (int i = 0; i < 4; i++)
			acc = add_ones(acc, {exp_frame[34 + 2*i], exp_frame[35 + 2*i]});
		exp_frame[36] = ~acc[15:8];
		exp_frame[37] = ~acc[7:0];
		return len;
	endfunction

	// ********************
	// Checks and report
	// ********************

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
		if (got !== exp) begin
			byte_errors++;
			$display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_word(input string name, input eth_lat_pkg::id16_t exp,
			input eth_lat_pkg::id16_t got);
		if (got !== exp) begin
			word_errors++;
			$display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_latency(input string name, input eth_lat_pkg::latency_t exp,
			input eth_lat_pkg::latency_t got);
		if (got !== exp) begin
			latency_errors++;
			$display("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, got);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			flag_errors++;
			$display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, got);
		end
	endtask

	task automatic report;
		int total;
		total = byte_errors + word_errors + latency_errors + flag_errors + other_errors;
		$display("Errors: byte %0d, word %0d, latency %0d, flag %0d, other %0d",
			byte_errors, word_errors, latency_errors, flag_errors, other_errors);
		if (total == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		other_errors++;
		report();
	endtask

	// ********************
	// Capture, compare, monitor
	// ********************

	always @(negedge clk) begin
		if (prev_stall) begin // Output must hold while the sink stalls
			check_byte("m_axis_tdata", prev_data, m_axis_tdata);
			check_flag("m_axis_tlast", prev_last, m_axis_tlast);
		end
		prev_stall = m_axis_tvalid && !m_axis_tready;
		prev_data = m_axis_tdata;
		prev_last = m_axis_tlast;
		if (m_axis_tvalid && m_axis_tready) begin
			check_flag("m_axis_tkeep", 1'b1, m_axis_tkeep);
			if (got_len == 0)
				begin_cyc = cyc; // First header byte transfers here
			if (got_len < MAX_BYTES) begin
				got_frame[got_len] = m_axis_tdata;
				got_last[got_len] = m_axis_tlast;
			end
			got_len++;
			if (m_axis_tlast) begin
				frames_seen++;
				-> frame_captured;
			end
		end
	end

	always @(frame_captured) begin
		check_word("frame_length", eth_lat_pkg::id16_t'(exp_len), eth_lat_pkg::id16_t'(got_len));
		for (int i = 0; i < exp_len && i < got_len && i < MAX_BYTES; i++) begin
			check_byte("m_axis_tdata", exp_frame[i], got_frame[i]);
			check_flag("m_axis_tlast", i == exp_len - 1, got_last[i]);
		end
		check_word("ip_header_sum", 16'hFFFF, region_sum(14, 10));
		check_word("icmp_sum", 16'hFFFF, region_sum(34, 4));
		frame_len = (got_len < MAX_BYTES) ? got_len : MAX_BYTES;
		got_len = 0;
	end

	always @(negedge clk) begin
		if (s_axis_tvalid && s_axis_tlast)
			exp_latency = eth_lat_pkg::latency_t'(cyc - begin_cyc);
		if (latency_valid) begin
			valid_seen++;
			check_latency("latency", exp_latency, latency);
		end
		if (timeout) begin
			timeouts_seen++;
			timeout_cyc = cyc;
			check_flag("busy", 1'b0, busy);
		end
	end

	// ********************
	// Stimulus
	// ********************

	task automatic pulse_trigger;
		@(posedge clk);
		#1 trigger = 1'b1;
		@(posedge clk);
		#1 trigger = 1'b0;
	endtask

	task automatic wait_frame(input int seen_before);
		int n;
		n = 0;
		while (frames_seen == seen_before && n < 2000) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (frames_seen == seen_before)
			abort_run("Transmit stream gave no complete frame within 2000 cycles");
	endtask

	task automatic wait_result(input int valid_before);
		int n;
		n = 0;
		while (valid_seen == valid_before && n < 3000) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (valid_seen == valid_before)
			abort_run("No latency_valid within 3000 cycles of the reply");
	endtask

	// Echoes the captured frame back with addresses swapped, corrupt 1 breaks
	// ping_id and corrupt 2 the destination MAC
	task automatic reflect_frame(input int delay, input int corrupt);
		logic [7:0] b;
		repeat (delay) @(posedge clk);
		for (int i = 0; i < frame_len; i++) begin
			if (i < 6)
				b = got_frame[i + 6];
			else if (i < 12)
				b = got_frame[i - 6];
			else if (i >= 26 && i < 30)
				b = got_frame[i + 4];
			else if (i >= 30 && i < 34)
				b = got_frame[i - 4];
			else if (i == 34)
				b = 8'h00; // Echo reply
			else
				b = got_frame[i];
			if ((corrupt == 1 && i == 41) || (corrupt == 2 && i == 0))
				b = ~b;
			@(posedge clk);
			#1;
			s_axis_tdata = b;
			s_axis_tvalid = 1'b1;
			s_axis_tlast = (i == frame_len - 1);
		end
		@(posedge clk);
		#1;
		s_axis_tvalid = 1'b0;
		s_axis_tlast = 1'b0;
	endtask

	task automatic run_ping(input int pad, input logic stalls, input int delay);
		int seen;
		int valids;
		@(posedge clk);
		#1;
		padding_size = eth_lat_pkg::id16_t'(pad);
		frame_id = frame_id + 16'd1;
		stall_mode = stalls;
		exp_len = build_frame(padding_size);
		seen = frames_seen;
		valids = valid_seen;
		pulse_trigger();
		check_flag("m_axis_tvalid", 1'b1, m_axis_tvalid);
		wait_frame(seen);
		reflect_frame(delay, 0);
		wait_result(valids);
		repeat (4) @(posedge clk);
		#1;
		if (valid_seen != valids + 1) begin
			other_errors++;
			$display("latency_valid pulsed %0d times for one reply", valid_seen - valids);
		end
		check_flag("busy", 1'b0, busy);
	endtask

	task automatic run_lost_ping;
		int seen;
		int valids;
		int timeouts;
		int n;
		@(posedge clk);
		#1;
		padding_size = 16'd0;
		stall_mode = 1'b0;
		exp_len = build_frame(padding_size);
		seen = frames_seen;
		valids = valid_seen;
		timeouts = timeouts_seen;
		pulse_trigger();
		wait_frame(seen);
		reflect_frame(10, 1);
		reflect_frame(10, 2);
		check_flag("busy", 1'b1, busy);
		pulse_trigger(); // Must be ignored while the ping is outstanding
		n = 0;
		while (timeouts_seen == timeouts && n < `ETH_LAT_TIMEOUT + 100) begin
			check_flag("m_axis_tvalid", 1'b0, m_axis_tvalid);
			@(posedge clk);
			#1;
			n++;
		end
		if (timeouts_seen == timeouts)
			abort_run("Lost ping gave no timeout pulse");
		// Limit reached on one cycle, pulse one edge later
		check_latency("timeout_cycles", eth_lat_pkg::latency_t'(`ETH_LAT_TIMEOUT + 1),
			eth_lat_pkg::latency_t'(timeout_cyc - begin_cyc));
		repeat (20) begin
			@(posedge clk);
			#1;
			check_flag("m_axis_tvalid", 1'b0, m_axis_tvalid);
		end
		if (valid_seen != valids) begin
			other_errors++;
			$display("A reply with a wrong ping_id or destination MAC was accepted");
		end
		if (timeouts_seen != timeouts + 1) begin
			other_errors++;
			$display("timeout pulsed %0d times for one lost ping", timeouts_seen - timeouts);
		end
	endtask

	initial begin
		seed = 32'h8efa_50c5;
		rst = 1'b1;
		trigger = 1'b0;
		mac_addr_src = 48'h02_00_5e_10_20_30;
		mac_addr_dst = 48'h02_00_5e_a0_b0_c0;
		ip_addr_src = 32'hc0a8_0a01;
		ip_addr_dst = 32'hc0a8_0a02;
		padding_size = 16'd0;
		frame_id = 16'h1234;
		log_id = 16'h00a5;
		ping_id = 16'h5a17;
		m_axis_tready = 1'b1;
		s_axis_tdata = 8'h00;
		s_axis_tvalid = 1'b0;
		s_axis_tlast = 1'b0;
		stall_mode = 1'b0;
		prev_stall = 1'b0;
		prev_data = 8'h00;
		prev_last = 1'b0;
		exp_latency = '0;
		exp_len = 0;
		got_len = 0;
		frame_len = 0;
		frames_seen = 0;
		valid_seen = 0;
		timeouts_seen = 0;
		cyc = 0;
		begin_cyc = 0;
		timeout_cyc = 0;
		byte_errors = 0;
		word_errors = 0;
		latency_errors = 0;
		flag_errors = 0;
		other_errors = 0;
		repeat (16) @(posedge clk);
		#1 rst = 1'b0;
		check_flag("m_axis_tvalid", 1'b0, m_axis_tvalid);
		check_flag("m_axis_tlast", 1'b0, m_axis_tlast);
		check_flag("latency_valid", 1'b0, latency_valid);
		check_flag("timeout", 1'b0, timeout);
		check_flag("busy", 1'b0, busy);
		run_ping(0, 1'b0, 10);
		run_ping(5, 1'b0, 100);
		run_ping(30, 1'b0, 700);
		run_ping(5, 1'b1, 10);
		run_ping(30, 1'b1, 100);
		run_lost_ping();
		report();
	end

endmodule
